// File: verilog/ixu_consts.svh
`ifndef IXU_CONSTS_SVH
`define IXU_CONSTS_SVH

// Datapath widths
`define IXU_XLEN   32
`define IXU_PREG_W 6
`define IXU_ROB_W  5
`define IXU_PC_W   30

// ALU opcodes
`define IXU_OP_ADD   7'd0
`define IXU_OP_SUB   7'd1
`define IXU_OP_AND   7'd2
`define IXU_OP_OR    7'd3
`define IXU_OP_XOR   7'd4
`define IXU_OP_SLL   7'd5
`define IXU_OP_SRL   7'd6
`define IXU_OP_SRA   7'd7
`define IXU_OP_SLT   7'd8
`define IXU_OP_SLTU  7'd9
`define IXU_OP_PASSB 7'd10

// Branch conditions in the low opcode bits of a conditional branch
`define IXU_BR_EQ  3'd0
`define IXU_BR_NE  3'd1
`define IXU_BR_LT  3'd4
`define IXU_BR_GE  3'd5
`define IXU_BR_LTU 3'd6
`define IXU_BR_GEU 3'd7

`endif

// File: verilog/ixu_pkg.sv
`include "ixu_consts.svh"

package ixu_pkg;

  typedef enum logic [2:0] {
    KIND_ALU    = 3'd0,
    KIND_LUI    = 3'd1,
    KIND_AUIPC  = 3'd2,
    KIND_BRANCH = 3'd3,
    KIND_JAL    = 3'd4,
    KIND_JALR   = 3'd5
  } ins_kind_e;

  // Branch information delivered with the instruction
  // btb_kind is 0 for conditional, 1 for jal and 2 for jalr
  typedef struct packed {
    logic                 btb_vld;
    logic [`IXU_PC_W-1:0] btb_target;
    logic [1:0]           btb_kind;
    logic [1:0]           bm_counter;
  } bpred_t;

  typedef struct packed {
    logic                   valid;
    logic [`IXU_ROB_W-1:0]  rob;
    logic [`IXU_PREG_W-1:0] rs1;
    logic [`IXU_PREG_W-1:0] rs2;
    logic [`IXU_PREG_W-1:0] dest;
    ins_kind_e              kind;
    logic [6:0]             opcode;
    logic                   use_imm;
    logic [`IXU_XLEN-1:0]   imm;
    logic [`IXU_PC_W-1:0]   pc;
    bpred_t                 pred;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`IXU_PREG_W-1:0] dest;
    logic [`IXU_XLEN-1:0]   data;
  } result_t;

  typedef struct packed {
    logic                  valid;
    logic [`IXU_ROB_W-1:0] rob;
    logic [`IXU_PC_W-1:0]  pc;
    logic                  is_cti;
    logic                  taken;
    logic [1:0]            kind;
    logic [`IXU_PC_W-1:0]  target;
    logic                  mispredict;
    logic                  counter_update;
    logic [1:0]            bm_counter;
  } branch_report_t;

endpackage

// File: verilog/ixu_alu.sv
`timescale 1ns/1ns
`include "ixu_consts.svh"

module ixu_alu (
  input  logic [`IXU_XLEN-1:0] a_i,
  input  logic [`IXU_XLEN-1:0] b_i,
  input  logic [6:0]           op_i,
  output logic [`IXU_XLEN-1:0] result_o,
  output logic [`IXU_XLEN-1:0] adder_o,
  output logic                 lts_o,
  output logic                 ltu_o,
  output logic                 eq_o
);

  logic                 sub;
  logic [`IXU_XLEN-1:0] b_add;
  logic                 carry;
  logic [4:0]           shamt;

  // Everything except ADD runs through the subtractor,
  // so branch opcodes always see valid compare flags
  assign sub   = (op_i != `IXU_OP_ADD);
  assign b_add = sub ? ~b_i : b_i;
  assign {carry, adder_o} = {1'b0, a_i} + {1'b0, b_add} + {{`IXU_XLEN{1'b0}}, sub};

  assign eq_o  = (adder_o == '0);
  // No carry out of a - b means a borrow
  assign ltu_o = ~carry;
  assign lts_o = (a_i[`IXU_XLEN-1] != b_i[`IXU_XLEN-1]) ? a_i[`IXU_XLEN-1]
                                                        : adder_o[`IXU_XLEN-1];

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      `IXU_OP_ADD:   result_o = adder_o;
      `IXU_OP_SUB:   result_o = adder_o;
      `IXU_OP_AND:   result_o = a_i & b_i;
      `IXU_OP_OR:    result_o = a_i | b_i;
      `IXU_OP_XOR:   result_o = a_i ^ b_i;
      `IXU_OP_SLL:   result_o = a_i << shamt;
      `IXU_OP_SRL:   result_o = a_i >> shamt;
      `IXU_OP_SRA:   result_o = $signed(a_i) >>> shamt;
      `IXU_OP_SLT:   result_o = {{(`IXU_XLEN-1){1'b0}}, lts_o};
      `IXU_OP_SLTU:  result_o = {{(`IXU_XLEN-1){1'b0}}, ltu_o};
      `IXU_OP_PASSB: result_o = b_i;
      default:       result_o = '0;
    endcase
  end

endmodule

// File: verilog/ixu_branch_unit.sv
`timescale 1ns/1ns
`include "ixu_consts.svh"

module ixu_branch_unit (
  input  ixu_pkg::ins_kind_e   kind_i,
  input  logic [2:0]           cond_i,
  input  logic                 lts_i,
  input  logic                 ltu_i,
  input  logic                 eq_i,
  input  logic [`IXU_XLEN-1:0] rs1_i,
  input  logic [`IXU_XLEN-1:0] offset_i,
  input  logic [`IXU_PC_W-1:0] pc_i,
  output logic [`IXU_XLEN-1:0] link_o,
  output logic                 taken_o,
  output logic [`IXU_PC_W-1:0] target_o
);

  logic [`IXU_XLEN-1:0] pc_byte;
  logic [`IXU_XLEN-1:0] base;
  logic [`IXU_XLEN-1:0] sum;
  logic                 cond_true;
  logic                 is_jalr;

  assign pc_byte = {pc_i, 2'b00};
  assign is_jalr = (kind_i == ixu_pkg::KIND_JALR);

  // Own adder since the ALU is busy with the compare
  assign base = is_jalr ? rs1_i : pc_byte;
  assign sum  = base + offset_i;

  // The JALR bit 0 clear falls below the word target
  assign target_o = sum[`IXU_XLEN-1:2];

  always_comb begin
    case (cond_i)
      `IXU_BR_EQ:  cond_true = eq_i;
      `IXU_BR_NE:  cond_true = ~eq_i;
      `IXU_BR_LT:  cond_true = lts_i;
      `IXU_BR_GE:  cond_true = ~lts_i;
      `IXU_BR_LTU: cond_true = ltu_i;
      `IXU_BR_GEU: cond_true = ~ltu_i;
      default:     cond_true = 1'b0;
    endcase
  end

  always_comb begin
    case (kind_i)
      ixu_pkg::KIND_JAL,
      ixu_pkg::KIND_JALR:   taken_o = 1'b1;
      ixu_pkg::KIND_BRANCH: taken_o = cond_true;
      default:              taken_o = 1'b0;
    endcase
  end

  // AUIPC shares the pc relative sum
  assign link_o = (kind_i == ixu_pkg::KIND_AUIPC) ? sum : pc_byte + 32'd4;

endmodule

// File: verilog/ixu_sc_pipe.sv
`timescale 1ns/1ns
`include "ixu_consts.svh"

module ixu_sc_pipe (
  input  logic                     core_clock_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  ixu_pkg::issue_t          issue_i,
  output logic [`IXU_PREG_W-1:0]   rs1_o,
  output logic [`IXU_PREG_W-1:0]   rs2_o,
  input  logic [`IXU_XLEN-1:0]     rs1_data_i,
  input  logic [`IXU_XLEN-1:0]     rs2_data_i,
  output ixu_pkg::result_t         wakeup_o,
  output ixu_pkg::result_t         ex_result_o,
  output ixu_pkg::result_t         wb_result_o,
  output ixu_pkg::branch_report_t  report_o
);

  logic                   is_lui;

  // Execute stage
  logic                   ex_valid;
  logic [`IXU_XLEN-1:0]   ex_a;
  logic [`IXU_XLEN-1:0]   ex_b;
  logic [6:0]             ex_op;
  logic [`IXU_XLEN-1:0]   ex_imm;
  logic [`IXU_PC_W-1:0]   ex_pc;
  logic [`IXU_PREG_W-1:0] ex_dest;
  logic [`IXU_ROB_W-1:0]  ex_rob;
  ixu_pkg::ins_kind_e     ex_kind;
  ixu_pkg::bpred_t        ex_pred;
  logic [`IXU_XLEN-1:0]   alu_result;
  logic                   lts;
  logic                   ltu;
  logic                   eq;
  logic [`IXU_XLEN-1:0]   link;
  logic                   taken;
  logic [`IXU_PC_W-1:0]   target;
  logic [`IXU_XLEN-1:0]   ex_data;

  // Writeback stage
  logic                   wb_valid;
  logic [`IXU_XLEN-1:0]   wb_data;
  logic [`IXU_PREG_W-1:0] wb_dest;
  logic [`IXU_ROB_W-1:0]  wb_rob;
  logic [`IXU_PC_W-1:0]   wb_pc;
  ixu_pkg::ins_kind_e     wb_kind;
  logic                   wb_taken;
  logic [`IXU_PC_W-1:0]   wb_target;
  ixu_pkg::bpred_t        wb_pred;
  logic                   wb_cti;
  logic [1:0]             wb_br_kind;
  logic                   mispredict;

  assign rs1_o  = issue_i.rs1;
  assign rs2_o  = issue_i.rs2;
  assign is_lui = (issue_i.kind == ixu_pkg::KIND_LUI);

  // Flush wins over a new issue
  always_ff @(posedge core_clock_i) begin
    if (rst_i || flush_i) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      ex_valid <= issue_i.valid;
      wb_valid <= ex_valid;
    end
  end

  // LUI goes through the ALU as a pass of the immediate
  always_ff @(posedge core_clock_i) begin
    ex_a    <= is_lui ? '0 : rs1_data_i;
    ex_b    <= (issue_i.use_imm || is_lui) ? issue_i.imm : rs2_data_i;
    ex_op   <= is_lui ? `IXU_OP_PASSB : issue_i.opcode;
    ex_imm  <= issue_i.imm;
    ex_pc   <= issue_i.pc;
    ex_dest <= issue_i.dest;
    ex_rob  <= issue_i.rob;
    ex_kind <= issue_i.kind;
    ex_pred <= issue_i.pred;
  end

  ixu_alu u_alu (
    .a_i      (ex_a),
    .b_i      (ex_b),
    .op_i     (ex_op),
    .result_o (alu_result),
    .adder_o  (),
    .lts_o    (lts),
    .ltu_o    (ltu),
    .eq_o     (eq)
  );

  ixu_branch_unit u_branch_unit (
    .kind_i   (ex_kind),
    .cond_i   (ex_op[2:0]),
    .lts_i    (lts),
    .ltu_i    (ltu),
    .eq_i     (eq),
    .rs1_i    (ex_a),
    .offset_i (ex_imm),
    .pc_i     (ex_pc),
    .link_o   (link),
    .taken_o  (taken),
    .target_o (target)
  );

  assign ex_data = (ex_kind == ixu_pkg::KIND_ALU || ex_kind == ixu_pkg::KIND_LUI) ?
                   alu_result : link;

  assign ex_result_o.valid = ex_valid && (ex_dest != '0);
  assign ex_result_o.dest  = ex_dest;
  assign ex_result_o.data  = ex_data;

  // Wakeup only needs the tag
  assign wakeup_o.valid = ex_result_o.valid;
  assign wakeup_o.dest  = ex_dest;
  assign wakeup_o.data  = '0;

  always_ff @(posedge core_clock_i) begin
    wb_data   <= ex_data;
    wb_dest   <= ex_dest;
    wb_rob    <= ex_rob;
    wb_pc     <= ex_pc;
    wb_kind   <= ex_kind;
    wb_taken  <= taken;
    wb_target <= target;
    wb_pred   <= ex_pred;
  end

  assign wb_result_o.valid = wb_valid && (wb_dest != '0);
  assign wb_result_o.dest  = wb_dest;
  assign wb_result_o.data  = wb_data;

  assign wb_cti = (wb_kind == ixu_pkg::KIND_BRANCH) || (wb_kind == ixu_pkg::KIND_JAL) ||
                  (wb_kind == ixu_pkg::KIND_JALR);

  // Same encoding as btb_kind
  assign wb_br_kind = (wb_kind == ixu_pkg::KIND_JAL)  ? 2'd1 :
                      (wb_kind == ixu_pkg::KIND_JALR) ? 2'd2 : 2'd0;

  always_comb begin
    if (!wb_cti) begin
      // A hit on a non transfer is a false redirect
      mispredict = wb_pred.btb_vld;
    end else if (!wb_pred.btb_vld) begin
      mispredict = wb_taken;
    end else begin
      mispredict = (wb_pred.btb_kind != wb_br_kind) ||
                   (wb_taken && (wb_pred.btb_target != wb_target)) ||
                   ((wb_kind == ixu_pkg::KIND_BRANCH) && (wb_pred.bm_counter[1] != wb_taken));
    end
  end

  assign report_o.valid          = wb_valid;
  assign report_o.rob            = wb_rob;
  assign report_o.pc             = wb_pc;
  assign report_o.is_cti         = wb_cti;
  assign report_o.taken          = wb_taken;
  assign report_o.kind           = wb_br_kind;
  assign report_o.target         = wb_taken ? wb_target : wb_pc + 30'd1;
  assign report_o.mispredict     = wb_valid && mispredict;
  assign report_o.counter_update = wb_valid && wb_cti && wb_pred.btb_vld && !mispredict;
  assign report_o.bm_counter     = wb_pred.bm_counter;

  // Nothing issued before or during a flush may reach writeback
  a_flush_kills_wb: assert property (
    @(posedge core_clock_i) disable iff (rst_i)
    flush_i |=> !wb_valid ##1 !wb_valid
  );

  // The issue side never gives a branch a destination
  a_branch_no_dest: assert property (
    @(posedge core_clock_i) disable iff (rst_i)
    (issue_i.valid && issue_i.kind == ixu_pkg::KIND_BRANCH) |-> (issue_i.dest == '0)
  );

endmodule

// File: verilog/ixu_regfile.sv
`timescale 1ns/1ns
`include "ixu_consts.svh"

module ixu_regfile (
  input  logic                   core_clock_i,
  input  logic                   rst_i,
  input  logic [`IXU_PREG_W-1:0] rs1_i,
  input  logic [`IXU_PREG_W-1:0] rs2_i,
  output logic [`IXU_XLEN-1:0]   rs1_data_o,
  output logic [`IXU_XLEN-1:0]   rs2_data_o,
  input  ixu_pkg::result_t       wr_i
);

  localparam int NUM_REGS = 1 << `IXU_PREG_W;

  logic [`IXU_XLEN-1:0] regs [NUM_REGS];
  logic                 wr_en;

  assign wr_en = wr_i.valid && (wr_i.dest != '0);

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_i.dest] <= wr_i.data;
    end
  end

  // Write first, so a same cycle read sees the writeback value
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (wr_en && wr_i.dest == rs1_i) begin
      rs1_data_o = wr_i.data;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
  end

  always_comb begin
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (wr_en && wr_i.dest == rs2_i) begin
      rs2_data_o = wr_i.data;
    end else begin
      rs2_data_o = regs[rs2_i];
    end
  end

  // The pipe filters out writes to register 0
  a_no_write_r0: assert property (
    @(posedge core_clock_i) disable iff (rst_i)
    wr_i.valid |-> (wr_i.dest != '0)
  );

endmodule

// File: verilog/ixu_top.sv
`timescale 1ns/1ns
`include "ixu_consts.svh"

module ixu_top (
  input  logic                    core_clock_i,
  input  logic                    rst_i,
  input  logic                    flush_i,
  input  ixu_pkg::issue_t         issue_i,
  output ixu_pkg::result_t        wakeup_o,
  output ixu_pkg::result_t        ex_result_o,
  output ixu_pkg::result_t        wb_result_o,
  output ixu_pkg::branch_report_t report_o
);

  logic [`IXU_PREG_W-1:0] rs1;
  logic [`IXU_PREG_W-1:0] rs2;
  logic [`IXU_XLEN-1:0]   rs1_data;
  logic [`IXU_XLEN-1:0]   rs2_data;

  ixu_regfile u_regfile (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rs1_data_o   (rs1_data),
    .rs2_data_o   (rs2_data),
    .wr_i         (wb_result_o)
  );

  ixu_sc_pipe u_sc_pipe (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .issue_i      (issue_i),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .wakeup_o     (wakeup_o),
    .ex_result_o  (ex_result_o),
    .wb_result_o  (wb_result_o),
    .report_o     (report_o)
  );

endmodule

// File: verif/tb_ixu_top.sv
`timescale 1ns/1ns
`include "ixu_consts.svh"

module tb_ixu_top;

  localparam int wb_timeout = 8;
  localparam logic [6:0] alu_ops [11] = '{
    `IXU_OP_ADD, `IXU_OP_SUB, `IXU_OP_AND, `IXU_OP_OR, `IXU_OP_XOR, `IXU_OP_SLL,
    `IXU_OP_SRL, `IXU_OP_SRA, `IXU_OP_SLT, `IXU_OP_SLTU, `IXU_OP_PASSB
  };
  localparam logic [2:0] br_conds [6] = '{
    `IXU_BR_EQ, `IXU_BR_NE, `IXU_BR_LT, `IXU_BR_GE, `IXU_BR_LTU, `IXU_BR_GEU
  };

  logic                    core_clock_i;
  logic                    rst_i;
  logic                    flush_i;
  ixu_pkg::issue_t         issue_i;
  ixu_pkg::result_t        wakeup_o;
  ixu_pkg::result_t        ex_result_o;
  ixu_pkg::result_t        wb_result_o;
  ixu_pkg::branch_report_t report_o;

  logic [31:0]             shadow [64];
  logic [31:0]             lcg_state;
  logic [4:0]              rob_next;
  ixu_pkg::branch_report_t rep_seen;

  ixu_top u_dut (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .issue_i      (issue_i),
    .wakeup_o     (wakeup_o),
    .ex_result_o  (ex_result_o),
    .wb_result_o  (wb_result_o),
    .report_o     (report_o)
  );

  always #2 core_clock_i = ~core_clock_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] alu_model(logic [6:0] op, logic [31:0] a, logic [31:0] b);
    case (op)
      `IXU_OP_ADD:   return a + b;
      `IXU_OP_SUB:   return a - b;
      `IXU_OP_AND:   return a & b;
      `IXU_OP_OR:    return a | b;
      `IXU_OP_XOR:   return a ^ b;
      `IXU_OP_SLL:   return a << b[4:0];
      `IXU_OP_SRL:   return a >> b[4:0];
      `IXU_OP_SRA:   return $signed(a) >>> b[4:0];
      `IXU_OP_SLT:   return {31'd0, $signed(a) < $signed(b)};
      `IXU_OP_SLTU:  return {31'd0, a < b};
      `IXU_OP_PASSB: return b;
      default:       return 32'd0;
    endcase
  endfunction

  function automatic logic cond_model(logic [2:0] cond, logic [31:0] a, logic [31:0] b);
    case (cond)
      `IXU_BR_EQ:  return a == b;
      `IXU_BR_NE:  return a != b;
      `IXU_BR_LT:  return $signed(a) < $signed(b);
      `IXU_BR_GE:  return $signed(a) >= $signed(b);
      `IXU_BR_LTU: return a < b;
      `IXU_BR_GEU: return a >= b;
      default:     return 1'b0;
    endcase
  endfunction

  function automatic ixu_pkg::issue_t make_ins(ixu_pkg::ins_kind_e kind, logic [6:0] op,
                                               logic [5:0] dest, logic [5:0] rs1,
                                               logic [5:0] rs2, logic use_imm,
                                               logic [31:0] imm, logic [29:0] pc);
    ixu_pkg::issue_t ins;
    ins         = '0;
    ins.valid   = 1'b1;
    ins.rob     = rob_next;
    ins.rs1     = rs1;
    ins.rs2     = rs2;
    ins.dest    = dest;
    ins.kind    = kind;
    ins.opcode  = op;
    ins.use_imm = use_imm;
    ins.imm     = imm;
    ins.pc      = pc;
    rob_next    = rob_next + 5'd1;
    return ins;
  endfunction

  task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_abort(string what);
    $display("Timed out waiting for %s at t=%0t", what, $time);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic next_cycle();
    @(posedge core_clock_i);
    #1;
  endtask

  task automatic check_result(string what, ixu_pkg::result_t r, logic [5:0] dest,
                              logic [31:0] data);
    check_eq({what, " valid"}, r.valid, dest != 6'd0);
    if (dest != 6'd0) begin
      check_eq({what, " dest"}, r.dest, dest);
      check_eq({what, " data"}, r.data, data);
    end
  endtask

  // Issue one instruction and follow it to writeback
  task automatic run_ins(ixu_pkg::issue_t ins, logic [31:0] exp_data);
    int cycles;
    issue_i = ins;
    next_cycle();
    issue_i = '0;
    check_result("ex_result", ex_result_o, ins.dest, exp_data);
    check_eq("wakeup valid", wakeup_o.valid, ins.dest != 6'd0);
    cycles = 1;
    while (!report_o.valid && cycles < wb_timeout) begin
      next_cycle();
      cycles++;
    end
    if (!report_o.valid) begin
      timeout_abort("the writeback report");
    end
    check_eq("writeback latency", cycles, 2);
    check_result("wb_result", wb_result_o, ins.dest, exp_data);
    check_eq("report rob", report_o.rob, ins.rob);
    check_eq("report pc", report_o.pc, ins.pc);
    rep_seen = report_o;
    if (ins.dest != 6'd0) begin
      shadow[ins.dest] = exp_data;
    end
  endtask

  // LUI ignores the opcode field
  task automatic load_reg(logic [5:0] r, logic [31:0] v);
    run_ins(make_ins(ixu_pkg::KIND_LUI, `IXU_OP_SUB, r, 6'd0, 6'd0, 1'b1, v, 30'd0), v);
  endtask

  task automatic check_pred(ixu_pkg::bpred_t p, logic cti, logic [1:0] k, logic taken,
                            logic [29:0] tgt, logic is_cond);
    logic misp;
    if (!cti) begin
      misp = p.btb_vld;
    end else if (!p.btb_vld) begin
      misp = taken;
    end else begin
      misp = (p.btb_kind != k) || (taken && p.btb_target != tgt) ||
             (is_cond && p.bm_counter[1] != taken);
    end
    check_eq("report mispredict", rep_seen.mispredict, misp);
    check_eq("report counter_update", rep_seen.counter_update, p.btb_vld && cti && !misp);
    check_eq("report bm_counter", rep_seen.bm_counter, p.bm_counter);
  endtask

  // pmode 0 no hit, 1 correct, 2 wrong target, 3 wrong kind, 4 wrong counter
  task automatic run_cti(ixu_pkg::ins_kind_e kind, logic [2:0] cond, logic [5:0] rs1,
                         logic [5:0] rs2, logic [5:0] dest, int pmode);
    logic [31:0]     r;
    logic [31:0]     imm;
    logic [29:0]     pc;
    logic [31:0]     sum;
    logic            taken;
    logic [1:0]      k;
    logic [29:0]     tgt;
    ixu_pkg::issue_t ins;
    r = lcg_next();
    imm = {{19{r[12]}}, r[12:2], 2'b00};
    r = lcg_next();
    pc = r[31:2];
    taken = 1'b1;
    if (kind == ixu_pkg::KIND_JALR) begin
      k = 2'd2;
      sum = (shadow[rs1] + imm) & ~32'd1;
    end else if (kind == ixu_pkg::KIND_JAL) begin
      k = 2'd1;
      sum = {pc, 2'b00} + imm;
    end else begin
      k = 2'd0;
      sum = {pc, 2'b00} + imm;
      taken = cond_model(cond, shadow[rs1], shadow[rs2]);
    end
    tgt = sum[31:2];
    // Upper opcode bits set so the ALU runs a compare
    ins = make_ins(kind, {4'b1000, cond}, dest, rs1, rs2, 1'b0, imm, pc);
    if (pmode != 0) begin
      ins.pred.btb_vld    = 1'b1;
      ins.pred.btb_target = (pmode == 2) ? tgt + 30'd1 : tgt;
      ins.pred.btb_kind   = (pmode == 3) ? k + 2'd1 : k;
      ins.pred.bm_counter = (taken ^ (pmode == 4)) ? 2'b11 : 2'b00;
    end
    run_ins(ins, {pc, 2'b00} + 32'd4);
    check_eq("report is_cti", rep_seen.is_cti, 1'b1);
    check_eq("report taken", rep_seen.taken, taken);
    check_eq("report kind", rep_seen.kind, k);
    check_eq("report target", rep_seen.target, taken ? tgt : pc + 30'd1);
    check_pred(ins.pred, 1'b1, k, taken, tgt, kind == ixu_pkg::KIND_BRANCH);
  endtask

  task automatic test_alu_ops();
    logic [31:0]     v;
    logic [31:0]     imm;
    ixu_pkg::issue_t ins;
    for (int r = 1; r <= 3; r++) begin
      v = lcg_next();
      load_reg(6'(r), {v[31:12], 12'd0});
      imm = {{20{v[11]}}, v[11:0]};
      ins = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'(r), 6'(r), 6'd0, 1'b1, imm, 30'd0);
      run_ins(ins, shadow[r] + imm);
    end
    for (int i = 0; i < 11; i++) begin
      ins = make_ins(ixu_pkg::KIND_ALU, alu_ops[i], 6'(10 + i), 6'd1, 6'd2, 1'b0, 32'd0, 30'd0);
      run_ins(ins, alu_model(alu_ops[i], shadow[1], shadow[2]));
      imm = lcg_next();
      ins = make_ins(ixu_pkg::KIND_ALU, alu_ops[i], 6'(24 + i), 6'd3, 6'd0, 1'b1, imm, 30'd0);
      run_ins(ins, alu_model(alu_ops[i], shadow[3], imm));
    end
  endtask

  task automatic test_back_to_back();
    logic [31:0] e1;
    logic [31:0] e2;
    logic [31:0] e3;
    e1 = shadow[1] + shadow[2];
    e2 = shadow[20] + 32'd5;
    issue_i = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd20, 6'd1, 6'd2, 1'b0, 32'd0, 30'd0);
    next_cycle();
    check_result("chain ex 1", ex_result_o, 6'd20, e1);
    check_eq("chain wakeup valid", wakeup_o.valid, 1'b1);
    check_eq("chain wakeup dest", wakeup_o.dest, 6'd20);
    // Right behind its producer with no bypass here, so r20 is still old
    issue_i = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd21, 6'd20, 6'd0, 1'b1, 32'd5, 30'd0);
    next_cycle();
    check_result("chain wb 1", wb_result_o, 6'd20, e1);
    check_result("chain ex 2", ex_result_o, 6'd21, e2);
    shadow[20] = e1;
    e3 = e1 + 32'd7;
    issue_i = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd22, 6'd20, 6'd0, 1'b1, 32'd7, 30'd0);
    next_cycle();
    check_result("chain wb 2", wb_result_o, 6'd21, e2);
    check_result("chain ex 3", ex_result_o, 6'd22, e3);
    shadow[21] = e2;
    issue_i = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd0, 6'd1, 6'd2, 1'b0, 32'd0, 30'd0);
    next_cycle();
    issue_i = '0;
    check_result("chain wb 3", wb_result_o, 6'd22, e3);
    check_eq("r0 ex valid", ex_result_o.valid, 1'b0);
    check_eq("r0 wakeup valid", wakeup_o.valid, 1'b0);
    shadow[22] = e3;
    next_cycle();
    check_eq("r0 wb valid", wb_result_o.valid, 1'b0);
    check_eq("r0 report valid", report_o.valid, 1'b1);
  endtask

  task automatic test_branches();
    logic [31:0]     x;
    logic [31:0]     r;
    logic [29:0]     pc;
    ixu_pkg::issue_t ins;
    x = lcg_next();
    load_reg(6'd30, x);
    load_reg(6'd31, x);
    load_reg(6'd32, lcg_next() | 32'h8000_0000);
    load_reg(6'd33, lcg_next() & 32'h7fff_ffff);
    load_reg(6'd34, lcg_next() & 32'h7fff_ffff);
    load_reg(6'd35, lcg_next() | 32'h8000_0000);
    load_reg(6'd36, lcg_next() | 32'd1);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        run_cti(ixu_pkg::KIND_BRANCH, br_conds[c], 6'(30 + 2 * p), 6'(31 + 2 * p), 6'd0, 0);
      end
    end
    run_cti(ixu_pkg::KIND_JAL, 3'd0, 6'd0, 6'd0, 6'd40, 0);
    run_cti(ixu_pkg::KIND_JALR, 3'd0, 6'd36, 6'd0, 6'd41, 0);
    r = lcg_next();
    pc = r[31:2];
    x = lcg_next();
    ins = make_ins(ixu_pkg::KIND_AUIPC, `IXU_OP_ADD, 6'd42, 6'd0, 6'd0, 1'b1, x, pc);
    run_ins(ins, {pc, 2'b00} + x);
    check_eq("auipc is_cti", rep_seen.is_cti, 1'b0);
    check_eq("auipc target", rep_seen.target, pc + 30'd1);
    check_pred(ins.pred, 1'b0, 2'd0, 1'b0, 30'd0, 1'b0);
  endtask

  task automatic test_predictions();
    ixu_pkg::issue_t ins;
    for (int m = 0; m < 5; m++) begin
      run_cti(ixu_pkg::KIND_BRANCH, `IXU_BR_LT, 6'd32, 6'd33, 6'd0, m);
      run_cti(ixu_pkg::KIND_BRANCH, `IXU_BR_LTU, 6'd32, 6'd33, 6'd0, m);
      run_cti(ixu_pkg::KIND_JAL, 3'd0, 6'd0, 6'd0, 6'd43, m);
      run_cti(ixu_pkg::KIND_JALR, 3'd0, 6'd36, 6'd0, 6'd44, m);
    end
    ins = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd45, 6'd1, 6'd2, 1'b0, 32'd0, 30'd9);
    ins.pred.btb_vld    = 1'b1;
    ins.pred.btb_target = 30'd100;
    ins.pred.bm_counter = 2'b11;
    run_ins(ins, shadow[1] + shadow[2]);
    check_eq("false hit is_cti", rep_seen.is_cti, 1'b0);
    check_pred(ins.pred, 1'b0, 2'd0, 1'b0, 30'd0, 1'b0);
  endtask

  task automatic test_flush();
    issue_i = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd1, 6'd3, 6'd0, 1'b1, 32'd1, 30'd0);
    next_cycle();
    // First one sits in execute while the second is on issue
    issue_i = make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd2, 6'd3, 6'd0, 1'b1, 32'd2, 30'd0);
    flush_i = 1'b1;
    next_cycle();
    issue_i = '0;
    flush_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      check_eq("flushed wb valid", wb_result_o.valid, 1'b0);
      check_eq("flushed report valid", report_o.valid, 1'b0);
      next_cycle();
    end
    run_ins(make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd50, 6'd1, 6'd0, 1'b1, 32'd0, 30'd0),
            shadow[1]);
    run_ins(make_ins(ixu_pkg::KIND_ALU, `IXU_OP_ADD, 6'd51, 6'd2, 6'd0, 1'b1, 32'd0, 30'd0),
            shadow[2]);
  endtask

  initial begin
    core_clock_i = 1'b0;
    rst_i        = 1'b1;
    flush_i      = 1'b0;
    issue_i      = '0;
    lcg_state    = 32'd83258;
    rob_next     = '0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge core_clock_i);
    #1;
    rst_i = 1'b0;
    check_eq("reset ex valid", ex_result_o.valid, 1'b0);
    check_eq("reset wakeup valid", wakeup_o.valid, 1'b0);
    check_eq("reset wb valid", wb_result_o.valid, 1'b0);
    check_eq("reset report valid", report_o.valid, 1'b0);
    test_alu_ops();
    test_back_to_back();
    test_branches();
    test_predictions();
    test_flush();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: tb.f
+incdir+verilog
verilog/ixu_pkg.sv
verilog/ixu_alu.sv
verilog/ixu_branch_unit.sv
verilog/ixu_sc_pipe.sv
verilog/ixu_regfile.sv
verilog/ixu_top.sv
verif/tb_ixu_top.sv

// File: Bender.yml
package:
  name: ixu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ixu_pkg.sv
      - verilog/ixu_alu.sv
      - verilog/ixu_branch_unit.sv
      - verilog/ixu_sc_pipe.sv
      - verilog/ixu_regfile.sv
      - verilog/ixu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_ixu_top.sv
